// File: conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// width of pixels, weights, bias and output words.
`define CONV_DATA_W 16

// number of kernel weights per beat, one output lane each.
`define CONV_LANES 3

// width of the user tag that rides along with every window.
`define CONV_USER_W 5

// accumulator width.
// a full product takes twice the data width and the rest is headroom
// for long windows.
`define CONV_ACC_W 40

`endif

// File: conv_pkg.sv
`include "conv_defines.svh"

package conv_pkg;

    // signed data word for pixels, weights, bias and outputs.
    typedef logic signed [`CONV_DATA_W-1:0] pixel_t;

    // full-precision product of two data words.
    typedef logic signed [2*`CONV_DATA_W-1:0] product_t;

    // per-lane running sum over a kernel window.
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    typedef logic [`CONV_USER_W-1:0] user_t;

    // win_first loads the accumulator with the next valid product.
    // win_run adds the next valid product to it.
    typedef enum logic {
        win_first,
        win_run
    } win_state_t;

endpackage

// File: conv_mult_stage.sv
`include "conv_defines.svh"

module conv_mult_stage (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               aclken,
    input  logic               s_valid,
    input  conv_pkg::pixel_t   s_pixel,
    input  conv_pkg::pixel_t   s_weight [`CONV_LANES],
    input  conv_pkg::pixel_t   s_bias,
    input  logic               s_last,
    input  conv_pkg::user_t    s_user,
    output logic               p_valid,
    output conv_pkg::product_t p_product [`CONV_LANES],
    output conv_pkg::pixel_t   p_bias,
    output logic               p_last,
    output conv_pkg::user_t    p_user
);
    import conv_pkg::*;

    product_t prod_d [`CONV_LANES];
    logic     accept;

    assign accept = aclken && s_valid;

    // one signed multiplier per lane, all sharing the same pixel.
    always_comb begin
        for (int i = 0; i < `CONV_LANES; i++) begin
            prod_d[i] = s_pixel * s_weight[i];
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            p_valid <= 1'b0;
            for (int i = 0; i < `CONV_LANES; i++) begin
                p_product[i] <= '0;
            end
        end else if (aclken) begin
            p_valid <= s_valid;
            for (int i = 0; i < `CONV_LANES; i++) begin
                p_product[i] <= prod_d[i];
            end
        end
    end

    // sideband only moves with an accepted beat.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            p_bias <= '0;
            p_last <= 1'b0;
            p_user <= '0;
        end else if (accept) begin
            p_bias <= s_bias;
            p_last <= s_last;
            p_user <= s_user;
        end
    end

endmodule

// File: conv_accum_stage.sv
`include "conv_defines.svh"

module conv_accum_stage (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               aclken,
    input  logic               p_valid,
    input  conv_pkg::product_t p_product [`CONV_LANES],
    input  conv_pkg::pixel_t   p_bias,
    input  logic               p_last,
    input  conv_pkg::user_t    p_user,
    output logic               a_valid,
    output conv_pkg::acc_t     a_sum [`CONV_LANES],
    output conv_pkg::user_t    a_user
);
    import conv_pkg::*;

    win_state_t state_q;
    acc_t       acc_q    [`CONV_LANES];
    acc_t       acc_next [`CONV_LANES];
    logic       win_end;

    assign win_end = p_valid && p_last;

    // the first beat of a window starts from zero instead of the stale sum.
    always_comb begin
        for (int i = 0; i < `CONV_LANES; i++) begin
            if (state_q == win_first) begin
                acc_next[i] = acc_t'(p_product[i]);
            end else begin
                acc_next[i] = acc_q[i] + acc_t'(p_product[i]);
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= win_first;
            for (int i = 0; i < `CONV_LANES; i++) begin
                acc_q[i] <= '0;
            end
        end else if (aclken && p_valid) begin
            for (int i = 0; i < `CONV_LANES; i++) begin
                acc_q[i] <= acc_next[i];
            end
            if (p_last) begin
                state_q <= win_first;
            end else begin
                state_q <= win_run;
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            a_valid <= 1'b0;
            a_user  <= '0;
            for (int i = 0; i < `CONV_LANES; i++) begin
                a_sum[i] <= '0;
            end
        end else if (aclken) begin
            a_valid <= win_end;
            if (win_end) begin
                a_user <= p_user;
                for (int i = 0; i < `CONV_LANES; i++) begin
                    a_sum[i] <= acc_next[i] + acc_t'(p_bias);
                end
            end
        end
    end

    a_valid_known: assert property (
        @(posedge aclk) disable iff (!arst_n)
        !$isunknown(a_valid)
    );

    // a window result only comes out of an enabled edge that closed a window.
    a_valid_from_last: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (aclken && !(p_valid && p_last)) |=> !a_valid
    );

endmodule

// File: conv_sat_stage.sv
`include "conv_defines.svh"

module conv_sat_stage (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             aclken,
    input  logic             a_valid,
    input  conv_pkg::acc_t   a_sum [`CONV_LANES],
    input  conv_pkg::user_t  a_user,
    output logic             m_valid,
    output conv_pkg::pixel_t m_data [`CONV_LANES],
    output conv_pkg::user_t  m_user
);
    import conv_pkg::*;

    localparam pixel_t pix_max = {1'b0, {(`CONV_DATA_W-1){1'b1}}};
    localparam pixel_t pix_min = {1'b1, {(`CONV_DATA_W-1){1'b0}}};

    pixel_t clamp_d [`CONV_LANES];

    // the limits are sign-extended to the accumulator width for the compare.
    always_comb begin
        for (int i = 0; i < `CONV_LANES; i++) begin
            if (a_sum[i] > acc_t'(pix_max)) begin
                clamp_d[i] = pix_max;
            end else if (a_sum[i] < acc_t'(pix_min)) begin
                clamp_d[i] = pix_min;
            end else begin
                clamp_d[i] = pixel_t'(a_sum[i]);
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
            m_user  <= '0;
            for (int i = 0; i < `CONV_LANES; i++) begin
                m_data[i] <= '0;
            end
        end else if (aclken) begin
            m_valid <= a_valid;
            m_user  <= a_user;
            for (int i = 0; i < `CONV_LANES; i++) begin
                m_data[i] <= clamp_d[i];
            end
        end
    end

    // an output strobe never appears without a window sum one enabled edge before.
    m_valid_from_sum: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (aclken && !a_valid) |=> !m_valid
    );

endmodule

// File: conv_unit.sv
`include "conv_defines.svh"

module conv_unit (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             aclken,
    input  logic             s_valid,
    input  conv_pkg::pixel_t s_pixel,
    input  conv_pkg::pixel_t s_weight [`CONV_LANES],
    input  conv_pkg::pixel_t s_bias,
    input  logic             s_last,
    input  conv_pkg::user_t  s_user,
    output logic             m_valid,
    output conv_pkg::pixel_t m_data [`CONV_LANES],
    output conv_pkg::user_t  m_user
);
    import conv_pkg::*;

    logic     p_valid;
    product_t p_product [`CONV_LANES];
    pixel_t   p_bias;
    logic     p_last;
    user_t    p_user;

    logic     a_valid;
    acc_t     a_sum [`CONV_LANES];
    user_t    a_user;

    conv_mult_stage mult_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .aclken    (aclken),
        .s_valid   (s_valid),
        .s_pixel   (s_pixel),
        .s_weight  (s_weight),
        .s_bias    (s_bias),
        .s_last    (s_last),
        .s_user    (s_user),
        .p_valid   (p_valid),
        .p_product (p_product),
        .p_bias    (p_bias),
        .p_last    (p_last),
        .p_user    (p_user)
    );

    conv_accum_stage accum_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .aclken    (aclken),
        .p_valid   (p_valid),
        .p_product (p_product),
        .p_bias    (p_bias),
        .p_last    (p_last),
        .p_user    (p_user),
        .a_valid   (a_valid),
        .a_sum     (a_sum),
        .a_user    (a_user)
    );

    conv_sat_stage sat_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .aclken  (aclken),
        .a_valid (a_valid),
        .a_sum   (a_sum),
        .a_user  (a_user),
        .m_valid (m_valid),
        .m_data  (m_data),
        .m_user  (m_user)
    );

endmodule

// File: conv_unit_tb.sv
`include "conv_defines.svh"

module conv_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import conv_pkg::*;

    localparam int num_windows = 200;
    localparam int max_len     = 8;
    localparam int max_gap     = 2;
    // each beat or idle cycle may cost two cycles with enable gaps, plus drain margin.
    localparam int timeout_cycles = num_windows * (max_len + max_gap) * 2 + 1000;

    logic   aclk;
    logic   arst_n;
    logic   aclken;
    logic   s_valid;
    pixel_t s_pixel;
    pixel_t s_weight [`CONV_LANES];
    pixel_t s_bias;
    logic   s_last;
    user_t  s_user;
    logic   m_valid;
    pixel_t m_data [`CONV_LANES];
    user_t  m_user;

    integer seed          = 61697;
    int     errors        = 0;
    int     outputs       = 0;
    int     cycles        = 0;
    int     enabled_edges = 0;
    logic   last_edge_en  = 1'b0;
    logic   in_window     = 1'b0;
    longint acc_model [`CONV_LANES];

    // expected results, one entry per window, in completion order.
    logic [`CONV_LANES*`CONV_DATA_W-1:0] exp_data_q [$];
    user_t                               exp_user_q [$];
    int                                  exp_edge_q [$];

    conv_unit conv_unit_i (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .aclken   (aclken),
        .s_valid  (s_valid),
        .s_pixel  (s_pixel),
        .s_weight (s_weight),
        .s_bias   (s_bias),
        .s_last   (s_last),
        .s_user   (s_user),
        .m_valid  (m_valid),
        .m_data   (m_data),
        .m_user   (m_user)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic pixel_t rand_word(input logic full_scale);
        if (full_scale) begin
            return pixel_t'($random(seed));
        end
        return pixel_t'(rand_range(-128, 127));
    endfunction

    // saturate a full-precision sum to the signed data range.
    function automatic pixel_t clamp_word(input longint sum);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (`CONV_DATA_W - 1)) - 1;
        lo = -(longint'(1) <<< (`CONV_DATA_W - 1));
        if (sum > hi) begin
            return pixel_t'(hi);
        end else if (sum < lo) begin
            return pixel_t'(lo);
        end
        return pixel_t'(sum);
    endfunction

    task automatic pick_enable();
        aclken = (rand_range(0, 7) != 0);
    endtask

    task automatic send_beat(input logic full_scale, input logic last);
        @(negedge aclk);
        s_valid = 1'b1;
        s_pixel = rand_word(full_scale);
        for (int i = 0; i < `CONV_LANES; i++) begin
            s_weight[i] = rand_word(full_scale);
        end
        s_bias = rand_word(full_scale);
        s_last = last;
        s_user = user_t'(rand_range(0, (1 << `CONV_USER_W) - 1));
        pick_enable();
        // the beat stays on the bus until an enabled edge takes it.
        while (!aclken) begin
            @(negedge aclk);
            pick_enable();
        end
    endtask

    task automatic idle_cycle();
        @(negedge aclk);
        s_valid = 1'b0;
        s_last  = 1'b0;
        s_pixel = rand_word(1'b1);
        pick_enable();
    endtask

    // reference model, fed by the inputs seen at each rising edge.
    always @(posedge aclk) begin : model_update
        logic [`CONV_LANES*`CONV_DATA_W-1:0] packed_exp;
        longint                              prod;
        if (!arst_n) begin
            last_edge_en = 1'b0;
            in_window    = 1'b0;
        end else begin
            last_edge_en = aclken;
            if (aclken && s_valid) begin
                for (int i = 0; i < `CONV_LANES; i++) begin
                    prod = longint'(s_pixel) * longint'(s_weight[i]);
                    if (in_window) begin
                        acc_model[i] = acc_model[i] + prod;
                    end else begin
                        acc_model[i] = prod;
                    end
                end
                in_window = !s_last;
                if (s_last) begin
                    for (int i = 0; i < `CONV_LANES; i++) begin
                        packed_exp[i*`CONV_DATA_W +: `CONV_DATA_W] =
                            clamp_word(acc_model[i] + longint'(s_bias));
                    end
                    exp_data_q.push_back(packed_exp);
                    exp_user_q.push_back(s_user);
                    // the accepting edge is the first of the three stage edges.
                    exp_edge_q.push_back(enabled_edges);
                end
            end
            if (aclken) begin
                enabled_edges++;
            end
        end
    end

    // outputs are settled half a cycle after the edge that produced them.
    always @(negedge aclk) begin : output_check
        logic [`CONV_LANES*`CONV_DATA_W-1:0] exp_data;
        user_t                               exp_user;
        int                                  exp_edge;
        if (arst_n && last_edge_en && m_valid) begin
            outputs++;
            assert (exp_user_q.size() > 0) else begin
                $display("output strobe at cycle %0d with no window pending", cycles);
                errors++;
            end
            if (exp_user_q.size() > 0) begin
                exp_data = exp_data_q.pop_front();
                exp_user = exp_user_q.pop_front();
                exp_edge = exp_edge_q.pop_front();
                for (int i = 0; i < `CONV_LANES; i++) begin
                    assert (m_data[i] == exp_data[i*`CONV_DATA_W +: `CONV_DATA_W]) else begin
                        $display("FAIL m_data[%0d]: got %h, expected %h", i, m_data[i],
                                 exp_data[i*`CONV_DATA_W +: `CONV_DATA_W]);
                        errors++;
                    end
                end
                assert (m_user == exp_user) else begin
                    $display("FAIL m_user: got %h, expected %h", m_user, exp_user);
                    errors++;
                end
                assert (enabled_edges == exp_edge + 3) else begin
                    $display("FAIL m_valid enabled edge: got %h, expected %h",
                             enabled_edges, exp_edge + 3);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < timeout_cycles) begin
            @(posedge aclk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", timeout_cycles);
        $display("test failed");
        $finish;
    end

    initial begin : stimulus
        int   len;
        int   gap;
        logic full_scale;
        arst_n  = 1'b0;
        aclken  = 1'b1;
        s_valid = 1'b0;
        s_pixel = '0;
        for (int i = 0; i < `CONV_LANES; i++) begin
            s_weight[i] = '0;
        end
        s_bias = '0;
        s_last = 1'b0;
        s_user = '0;
        repeat (3) @(negedge aclk);
        arst_n = 1'b1;

        for (int w = 0; w < num_windows; w++) begin
            len = rand_range(1, max_len);
            gap = rand_range(0, max_gap);
            // every fifth window runs near full scale to drive the clamp.
            full_scale = (w % 5 == 4);
            for (int b = 0; b < len; b++) begin
                send_beat(full_scale, b == len - 1);
            end
            repeat (gap) idle_cycle();
        end

        while (exp_user_q.size() > 0) begin
            idle_cycle();
        end
        repeat (20) idle_cycle();

        assert (outputs == num_windows) else begin
            $display("FAIL outputs: got %h, expected %h", outputs, num_windows);
            errors++;
        end
        assert (exp_user_q.size() == 0) else begin
            $display("%0d windows never came out of the pipeline", exp_user_q.size());
            errors++;
        end

        $display("errors: %0d, outputs: %0d of %0d windows", errors, outputs, num_windows);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
conv_pkg.sv
conv_mult_stage.sv
conv_accum_stage.sv
conv_sat_stage.sv
conv_unit.sv
conv_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module conv_unit_tb -o sim_conv_unit

./obj_dir/sim_conv_unit > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
